// File: include/dma_rd_settings.svh
`ifndef DMA_RD_SETTINGS_SVH
`define DMA_RD_SETTINGS_SVH

// Byte address width of the AXI read port
`define DMA_ADDR_W 32

// Only 32-bit words are supported
`define DMA_DATA_W 32

// Command length in words
`define DMA_LEN_W 10

// log2 of the longest burst of 8 beats
`define DMA_BURST_W 3

// Command tag carried on every stream beat
`define DMA_TAG_W 4

// Burst channels and the width of a channel index
`define DMA_NUM_CH 4
`define DMA_CH_W 2

// 4 KB page that a burst must stay inside
`define DMA_PAGE_BYTES 13'h1000

`endif

// File: rtl/dma_rd_pkg.sv
`default_nettype none

`include "dma_rd_settings.svh"

package dma_rd_pkg;

   typedef logic [`DMA_ADDR_W-1:0] addr_t;
   typedef logic [`DMA_DATA_W-1:0] data_t;
   typedef logic [`DMA_LEN_W-1:0] wlen_t;
   typedef logic [`DMA_BURST_W-1:0] arlen_t;
   typedef logic [`DMA_BURST_W:0] beats_t;
   typedef logic [`DMA_TAG_W-1:0] tag_t;
   typedef logic [`DMA_CH_W-1:0] chan_t;

   typedef struct packed {
      addr_t addr;
      wlen_t len;
      tag_t tag;
   } rd_cmd_t;

   // One AXI INCR burst with ARLEN as beats minus one
   typedef struct packed {
      addr_t addr;
      arlen_t len;
   } ar_req_t;

   typedef struct packed {
      data_t data;
      logic last;
   } r_beat_t;

   // last marks the final word of the whole command
   typedef struct packed {
      data_t data;
      tag_t tag;
      logic last;
   } stream_beat_t;

   typedef enum logic [1:0] {IDLE, SIZE, ADDR, DATA} burst_state_t;

   typedef enum logic [1:0] {ARB_IDLE, ARB_ADDR, ARB_DATA} arb_state_t;

endpackage

`default_nettype wire

// File: rtl/rd_cmd_dispatch.sv
`default_nettype none

`include "dma_rd_settings.svh"

module rd_cmd_dispatch (
   input wire logic cmd_valid_i,
   input wire dma_rd_pkg::rd_cmd_t cmd_i,
   output logic cmd_ready_o,

   input wire logic [`DMA_NUM_CH-1:0] slot_ready_i,
   output logic [`DMA_NUM_CH-1:0] slot_valid_o,
   output dma_rd_pkg::rd_cmd_t slot_cmd_o
);

   logic any_idle;
   dma_rd_pkg::chan_t sel;

   // Lowest-numbered idle channel wins
   always_comb begin
      any_idle = 1'b0;
      sel = '0;
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         if (slot_ready_i[i] && !any_idle) begin
            any_idle = 1'b1;
            sel = dma_rd_pkg::chan_t'(i);
         end
      end
   end

   assign cmd_ready_o = any_idle;

   // Handshake goes to the chosen channel only
   always_comb begin
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         slot_valid_o[i] = cmd_valid_i && any_idle && (sel == dma_rd_pkg::chan_t'(i));
      end
   end

   // Payload is broadcast and only the selected slot latches it
   assign slot_cmd_o = cmd_i;

endmodule

`default_nettype wire

// File: rtl/rd_burst_channel.sv
`default_nettype none

`include "dma_rd_settings.svh"

module rd_burst_channel (
   input wire logic clk_i,
   input wire logic rst_n_i,

   input wire logic cmd_valid_i,
   input wire dma_rd_pkg::rd_cmd_t cmd_i,
   output logic cmd_ready_o,

   output logic ar_valid_o,
   output dma_rd_pkg::ar_req_t ar_req_o,
   input wire logic ar_ready_i,

   input wire logic r_valid_i,
   input wire dma_rd_pkg::r_beat_t r_beat_i,
   output logic r_ready_o,

   output logic out_valid_o,
   output dma_rd_pkg::stream_beat_t out_beat_o,
   input wire logic out_ready_i
);

   localparam dma_rd_pkg::beats_t MAX_BEATS = {1'b1, {`DMA_BURST_W{1'b0}}};

   dma_rd_pkg::burst_state_t state_q;
   logic active_q;

   dma_rd_pkg::addr_t addr_q;
   dma_rd_pkg::wlen_t remain_q;
   dma_rd_pkg::tag_t tag_q;
   dma_rd_pkg::arlen_t arlen_q;

   logic [12:0] page_bytes;
   logic [10:0] page_words;
   dma_rd_pkg::beats_t len_beats;
   dma_rd_pkg::beats_t burst_beats;
   dma_rd_pkg::beats_t done_beats;
   dma_rd_pkg::addr_t burst_bytes;

   logic cmd_fire;
   logic r_fire;
   logic burst_end;

   // Held low through reset, set on the first cycle out of it
   always_ff @(posedge clk_i) begin
      active_q <= rst_n_i;
   end

   assign cmd_ready_o = active_q && (state_q == dma_rd_pkg::IDLE);
   assign cmd_fire = cmd_valid_i && cmd_ready_o;

   // Burst size is the remaining words capped by max burst and the 4 KB page
   always_comb begin
      page_bytes = `DMA_PAGE_BYTES - {1'b0, addr_q[11:0]};
      page_words = page_bytes[12:2];
      if (remain_q >= dma_rd_pkg::wlen_t'(MAX_BEATS)) begin
         len_beats = MAX_BEATS;
      end else begin
         len_beats = dma_rd_pkg::beats_t'(remain_q);
      end
      if (page_words < 11'(len_beats)) begin
         burst_beats = dma_rd_pkg::beats_t'(page_words);
      end else begin
         burst_beats = len_beats;
      end
   end

   assign done_beats = dma_rd_pkg::beats_t'(arlen_q) + dma_rd_pkg::beats_t'(1);
   assign burst_bytes = dma_rd_pkg::addr_t'({done_beats, 2'b00});

   assign ar_valid_o = (state_q == dma_rd_pkg::ADDR);
   assign ar_req_o.addr = addr_q;
   assign ar_req_o.len = arlen_q;

   // Read data passes straight through to the stream
   assign r_ready_o = (state_q == dma_rd_pkg::DATA) && out_ready_i;
   assign out_valid_o = (state_q == dma_rd_pkg::DATA) && r_valid_i;
   assign out_beat_o.data = r_beat_i.data;
   assign out_beat_o.tag = tag_q;
   assign out_beat_o.last = r_beat_i.last && (remain_q == '0);

   assign r_fire = r_valid_i && r_ready_o;
   assign burst_end = r_fire && r_beat_i.last;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= dma_rd_pkg::IDLE;
      end else begin
         case (state_q)
            dma_rd_pkg::IDLE: begin
               // Zero-length commands are taken and dropped here
               if (cmd_fire && (cmd_i.len != '0)) begin
                  state_q <= dma_rd_pkg::SIZE;
               end
            end
            dma_rd_pkg::SIZE: begin
               state_q <= dma_rd_pkg::ADDR;
            end
            dma_rd_pkg::ADDR: begin
               if (ar_ready_i) begin
                  state_q <= dma_rd_pkg::DATA;
               end
            end
            dma_rd_pkg::DATA: begin
               if (burst_end) begin
                  state_q <= (remain_q == '0) ? dma_rd_pkg::IDLE : dma_rd_pkg::SIZE;
               end
            end
            default: begin
               state_q <= dma_rd_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_fire) begin
         addr_q <= cmd_i.addr;
         remain_q <= cmd_i.len;
         tag_q <= cmd_i.tag;
      end
      if (state_q == dma_rd_pkg::SIZE) begin
         remain_q <= remain_q - dma_rd_pkg::wlen_t'(burst_beats);
         arlen_q <= dma_rd_pkg::arlen_t'(burst_beats - dma_rd_pkg::beats_t'(1));
      end
      if ((state_q == dma_rd_pkg::DATA) && burst_end) begin
         addr_q <= addr_q + burst_bytes;
      end
   end

endmodule

`default_nettype wire

// File: rtl/axi_rd_arbiter.sv
`default_nettype none

`include "dma_rd_settings.svh"

module axi_rd_arbiter (
   input wire logic clk_i,
   input wire logic rst_n_i,

   input wire logic [`DMA_NUM_CH-1:0] ar_valid_i,
   input wire dma_rd_pkg::ar_req_t [`DMA_NUM_CH-1:0] ar_req_i,
   output logic [`DMA_NUM_CH-1:0] ar_ready_o,

   output logic [`DMA_NUM_CH-1:0] r_valid_o,
   output dma_rd_pkg::r_beat_t r_beat_o,
   input wire logic [`DMA_NUM_CH-1:0] r_ready_i,

   output logic m_arvalid_o,
   output dma_rd_pkg::addr_t m_araddr_o,
   output dma_rd_pkg::arlen_t m_arlen_o,
   input wire logic m_arready_i,

   input wire logic m_rvalid_i,
   input wire dma_rd_pkg::data_t m_rdata_i,
   input wire logic m_rlast_i,
   output logic m_rready_o
);

   dma_rd_pkg::arb_state_t state_q;
   dma_rd_pkg::chan_t grant_q;

   logic found;
   dma_rd_pkg::chan_t winner;

   // Round-robin search starts just after the last granted channel
   always_comb begin
      int idx;
      found = 1'b0;
      winner = grant_q;
      for (int k = 1; k <= `DMA_NUM_CH; k++) begin
         idx = (int'(grant_q) + k) % `DMA_NUM_CH;
         if (!found && ar_valid_i[idx]) begin
            found = 1'b1;
            winner = dma_rd_pkg::chan_t'(idx);
         end
      end
   end

   assign m_arvalid_o = (state_q == dma_rd_pkg::ARB_ADDR) && ar_valid_i[grant_q];
   assign m_araddr_o = ar_req_i[grant_q].addr;
   assign m_arlen_o = ar_req_i[grant_q].len;

   assign m_rready_o = (state_q == dma_rd_pkg::ARB_DATA) && r_ready_i[grant_q];
   assign r_beat_o.data = m_rdata_i;
   assign r_beat_o.last = m_rlast_i;

   // Handshakes reach the granted channel only
   always_comb begin
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         ar_ready_o[i] = (state_q == dma_rd_pkg::ARB_ADDR) &&
                         (grant_q == dma_rd_pkg::chan_t'(i)) && m_arready_i;
         r_valid_o[i] = (state_q == dma_rd_pkg::ARB_DATA) &&
                        (grant_q == dma_rd_pkg::chan_t'(i)) && m_rvalid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= dma_rd_pkg::ARB_IDLE;
         // Channel 0 gets the first grant
         grant_q <= dma_rd_pkg::chan_t'(`DMA_NUM_CH - 1);
      end else begin
         case (state_q)
            dma_rd_pkg::ARB_IDLE: begin
               if (found) begin
                  grant_q <= winner;
                  state_q <= dma_rd_pkg::ARB_ADDR;
               end
            end
            dma_rd_pkg::ARB_ADDR: begin
               if (m_arvalid_o && m_arready_i) begin
                  state_q <= dma_rd_pkg::ARB_DATA;
               end
            end
            dma_rd_pkg::ARB_DATA: begin
               if (m_rvalid_i && m_rready_o && m_rlast_i) begin
                  state_q <= dma_rd_pkg::ARB_IDLE;
               end
            end
            default: begin
               state_q <= dma_rd_pkg::ARB_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/dma_rd_top.sv
`default_nettype none

`include "dma_rd_settings.svh"

module dma_rd_top (
   input wire logic clk_i,
   input wire logic rst_n_i,

   input wire logic cmd_valid_i,
   input wire dma_rd_pkg::rd_cmd_t cmd_i,
   output logic cmd_ready_o,

   output logic m_arvalid_o,
   output dma_rd_pkg::addr_t m_araddr_o,
   output dma_rd_pkg::arlen_t m_arlen_o,
   input wire logic m_arready_i,
   input wire logic m_rvalid_i,
   input wire dma_rd_pkg::data_t m_rdata_i,
   input wire logic m_rlast_i,
   output logic m_rready_o,

   output logic [`DMA_NUM_CH-1:0] out_valid_o,
   output dma_rd_pkg::stream_beat_t [`DMA_NUM_CH-1:0] out_beat_o,
   input wire logic [`DMA_NUM_CH-1:0] out_ready_i
);

   logic [`DMA_NUM_CH-1:0] slot_valid;
   logic [`DMA_NUM_CH-1:0] slot_ready;
   dma_rd_pkg::rd_cmd_t slot_cmd;

   logic [`DMA_NUM_CH-1:0] ar_valid;
   dma_rd_pkg::ar_req_t [`DMA_NUM_CH-1:0] ar_req;
   logic [`DMA_NUM_CH-1:0] ar_ready;

   logic [`DMA_NUM_CH-1:0] r_valid;
   dma_rd_pkg::r_beat_t r_beat;
   logic [`DMA_NUM_CH-1:0] r_ready;

   rd_cmd_dispatch u_dispatch (
      .cmd_valid_i (cmd_valid_i),
      .cmd_i (cmd_i),
      .cmd_ready_o (cmd_ready_o),
      .slot_ready_i (slot_ready),
      .slot_valid_o (slot_valid),
      .slot_cmd_o (slot_cmd)
   );

   for (genvar c = 0; c < `DMA_NUM_CH; c++) begin : g_ch
      rd_burst_channel u_channel (
         .clk_i (clk_i),
         .rst_n_i (rst_n_i),
         .cmd_valid_i (slot_valid[c]),
         .cmd_i (slot_cmd),
         .cmd_ready_o (slot_ready[c]),
         .ar_valid_o (ar_valid[c]),
         .ar_req_o (ar_req[c]),
         .ar_ready_i (ar_ready[c]),
         .r_valid_i (r_valid[c]),
         .r_beat_i (r_beat),
         .r_ready_o (r_ready[c]),
         .out_valid_o (out_valid_o[c]),
         .out_beat_o (out_beat_o[c]),
         .out_ready_i (out_ready_i[c])
      );
   end

   axi_rd_arbiter u_arbiter (
      .clk_i (clk_i),
      .rst_n_i (rst_n_i),
      .ar_valid_i (ar_valid),
      .ar_req_i (ar_req),
      .ar_ready_o (ar_ready),
      .r_valid_o (r_valid),
      .r_beat_o (r_beat),
      .r_ready_i (r_ready),
      .m_arvalid_o (m_arvalid_o),
      .m_araddr_o (m_araddr_o),
      .m_arlen_o (m_arlen_o),
      .m_arready_i (m_arready_i),
      .m_rvalid_i (m_rvalid_i),
      .m_rdata_i (m_rdata_i),
      .m_rlast_i (m_rlast_i),
      .m_rready_o (m_rready_o)
   );

endmodule

`default_nettype wire

// File: testbench/tb_dma_rd.sv
`default_nettype none

`include "dma_rd_settings.svh"

module tb_dma_rd;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] SEED = 32'hfddd;
   localparam int NUM_TAGS = 1 << `DMA_TAG_W;
   localparam dma_rd_pkg::tag_t ZERO_TAG = 4'hf;
   localparam dma_rd_pkg::tag_t LAST_TAG = 4'he;

   logic clk_i = 1'b0;
   logic rst_n_i;
   logic cmd_valid_i;
   dma_rd_pkg::rd_cmd_t cmd_i;
   logic cmd_ready_o;
   logic m_arvalid_o;
   dma_rd_pkg::addr_t m_araddr_o;
   dma_rd_pkg::arlen_t m_arlen_o;
   logic m_arready_i;
   logic m_rvalid_i;
   dma_rd_pkg::data_t m_rdata_i;
   logic m_rlast_i;
   logic m_rready_o;
   logic [`DMA_NUM_CH-1:0] out_valid_o;
   dma_rd_pkg::stream_beat_t [`DMA_NUM_CH-1:0] out_beat_o;
   logic [`DMA_NUM_CH-1:0] out_ready_i;

   // Expectation table with one open command per tag
   dma_rd_pkg::addr_t exp_addr [NUM_TAGS];
   dma_rd_pkg::wlen_t exp_len [NUM_TAGS];
   int tag_issued [NUM_TAGS] = '{default: 0};
   int tag_done [NUM_TAGS] = '{default: 0};
   dma_rd_pkg::addr_t pos [NUM_TAGS] = '{default: '0};
   dma_rd_pkg::tag_t next_tag = '0;
   int issued_cmds = 0;
   int done_cmds = 0;
   int words_issued = 0;
   int ar_beats = 0;
   logic rand_ready = 1'b0;

   dma_rd_top UUT (.*);

   always #4 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Memory contents as a function of the byte address
   function automatic dma_rd_pkg::data_t mem_word(input dma_rd_pkg::addr_t a);
      return {a[24:0], a[31:25]} ^ 32'hc3a5_5a3c;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // Called at 1 ns after an edge, returns at the same offset
   task automatic issue_cmd(input dma_rd_pkg::addr_t addr, input dma_rd_pkg::wlen_t len,
                            input logic expect_stall);
      dma_rd_pkg::tag_t tag;
      int base;
      logic accepted;
      if (len == '0) begin
         tag = ZERO_TAG;
      end else begin
         tag = next_tag;
         next_tag = (next_tag == LAST_TAG) ? '0 : next_tag + 4'd1;
         while (tag_issued[tag] != tag_done[tag]) begin
            @(posedge clk_i);
            #1;
         end
         exp_addr[tag] = addr;
         exp_len[tag] = len;
         tag_issued[tag] = tag_issued[tag] + 1;
         issued_cmds = issued_cmds + 1;
         words_issued = words_issued + int'(len);
      end
      base = done_cmds;
      cmd_valid_i = 1'b1;
      cmd_i.addr = addr;
      cmd_i.len = len;
      cmd_i.tag = tag;
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk_i);
         // All channels busy until one finishes its last beat
         if (expect_stall && (done_cmds == base)) begin
            check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd0);
         end
         accepted = cmd_ready_o;
      end
      #1;
      cmd_valid_i = 1'b0;
   endtask

   task automatic drain();
      while (done_cmds != issued_cmds) begin
         @(posedge clk_i);
         #1;
      end
      repeat (4) @(posedge clk_i);
      #1;
   endtask

   initial begin : stimulus
      logic [31:0] stim_rng;
      stim_rng = SEED;
      rst_n_i = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_i = '0;
      repeat (8) @(posedge clk_i);
      check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd0);
      check_value("m_arvalid_o", 32'(m_arvalid_o), 32'd0);
      check_value("m_rready_o", 32'(m_rready_o), 32'd0);
      check_value("out_valid_o", 32'(out_valid_o), 32'd0);
      #1;
      rst_n_i = 1'b1;
      issue_cmd(32'h0000_1000, 10'd20, 1'b0);
      drain();
      // Starts just below a 4 KB boundary
      issue_cmd(32'h0000_1ff4, 10'd9, 1'b0);
      issue_cmd(32'h0002_2fe8, 10'd37, 1'b0);
      issue_cmd(32'h0003_0ffc, 10'd2, 1'b0);
      drain();
      issue_cmd(32'h0004_0000, 10'd0, 1'b0);
      issue_cmd(32'h0004_0100, 10'd11, 1'b0);
      drain();
      for (int i = 0; i < 4; i++) begin
         issue_cmd(32'h0005_0fc0 + 32'(i) * 32'h400, 10'd24, 1'b0);
      end
      drain();
      rand_ready = 1'b1;
      for (int i = 0; i < 16; i++) begin
         stim_rng = lcg_next(stim_rng);
         issue_cmd({12'h000, stim_rng[19:2], 2'b00},
                   dma_rd_pkg::wlen_t'(stim_rng[26:21]) + 10'd1, 1'b0);
      end
      drain();
      for (int i = 0; i < 4; i++) begin
         issue_cmd(32'h0007_0000 + 32'(i) * 32'h1000, 10'd64, 1'b0);
      end
      issue_cmd(32'h0008_0ff0, 10'd30, 1'b1);
      drain();
      check_value("total AR beats", 32'(ar_beats), 32'(words_issued));
      $display("All tests passed!");
      $finish;
   end

   initial begin : mem_model
      logic [31:0] rng;
      dma_rd_pkg::addr_t ar_addr;
      dma_rd_pkg::arlen_t ar_len;
      int unsigned span;
      rng = SEED;
      m_arready_i = 1'b0;
      m_rvalid_i = 1'b0;
      m_rdata_i = '0;
      m_rlast_i = 1'b0;
      wait (rst_n_i === 1'b1);
      m_arready_i = 1'b1;
      forever begin
         @(posedge clk_i);
         if (m_arvalid_o) begin
            ar_addr = m_araddr_o;
            ar_len = m_arlen_o;
            ar_beats = ar_beats + int'(ar_len) + 1;
            span = 32'(ar_addr[11:0]) + 4 * (32'(ar_len) + 1);
            check_value("m_araddr_o[1:0]", 32'(ar_addr[1:0]), 32'd0);
            if (span > 4096) begin
               fail_run($sformatf("burst at 0x%h of %0d beats crosses a 4 KB boundary",
                                  ar_addr, int'(ar_len) + 1));
            end
            #1;
            m_arready_i = 1'b0;
            rng = lcg_next(rng);
            repeat (rng[9:8]) begin
               @(posedge clk_i);
               #1;
            end
            for (int b = 0; b <= int'(ar_len); b++) begin
               m_rvalid_i = 1'b1;
               m_rdata_i = mem_word(ar_addr + dma_rd_pkg::addr_t'(4 * b));
               m_rlast_i = (b == int'(ar_len));
               @(posedge clk_i);
               while (!m_rready_o) @(posedge clk_i);
               #1;
            end
            m_rvalid_i = 1'b0;
            m_rlast_i = 1'b0;
            m_arready_i = 1'b1;
         end
      end
   end

   initial begin : ready_drive
      logic [31:0] rng;
      rng = SEED;
      out_ready_i = '1;
      forever begin
         @(posedge clk_i);
         #1;
         rng = lcg_next(rng);
         for (int c = 0; c < `DMA_NUM_CH; c++) begin
            out_ready_i[c] = !rand_ready || (rng[16+2*c +: 2] != 2'b00);
         end
      end
   end

   // Each channel's stream checked at every edge
   always @(posedge clk_i) begin : stream_check
      dma_rd_pkg::tag_t t;
      dma_rd_pkg::addr_t last_pos;
      if (rst_n_i) begin
         for (int c = 0; c < `DMA_NUM_CH; c++) begin
            if (out_valid_o[c] && out_ready_i[c]) begin
               t = out_beat_o[c].tag;
               if (tag_issued[t] == tag_done[t]) begin
                  fail_run($sformatf("channel %0d sent a beat for tag %0d with no open command",
                                     c, t));
               end
               last_pos = dma_rd_pkg::addr_t'(exp_len[t]) - 32'd1;
               check_value($sformatf("out_beat_o[%0d].data", c), out_beat_o[c].data,
                           mem_word(exp_addr[t] + (pos[t] << 2)));
               check_value($sformatf("out_beat_o[%0d].last", c), 32'(out_beat_o[c].last),
                           32'(pos[t] == last_pos));
               if (pos[t] == last_pos) begin
                  pos[t] = '0;
                  tag_done[t] = tag_done[t] + 1;
                  done_cmds = done_cmds + 1;
               end else begin
                  pos[t] = pos[t] + 32'd1;
               end
            end
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk_i);
         cycles = cycles + 1;
         if (cycles > 200 * words_issued + 2000) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d commands done",
                               cycles, done_cmds, issued_cmds));
         end
      end
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
rtl/dma_rd_pkg.sv
rtl/rd_cmd_dispatch.sv
rtl/rd_burst_channel.sv
rtl/axi_rd_arbiter.sv
rtl/dma_rd_top.sv
testbench/tb_dma_rd.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/100ps -j 0
TOP := tb_dma_rd
FLIST := flist.f
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
